/* src/opl3_settings.svh */
`ifndef OPL3_SETTINGS_SVH
`define OPL3_SETTINGS_SVH

// ##########################################################################
// Register field widths.
// ##########################################################################
`define OPL3_FNUM_W     10  // Frequency number.
`define OPL3_BLOCK_W    3   // Octave.
`define OPL3_MULT_W     4   // Multiplier select.
`define OPL3_WS_W       2   // Waveform select.

// ##########################################################################
// Datapath and bus widths.
// ##########################################################################
`define OPL3_ENV_W      4   // Attenuation in shift steps.
`define OPL3_PHASE_W    20  // Phase accumulator.
`define OPL3_OUT_W      13  // Signed sample.
`define OPL3_VIB_IDX_W  13  // Vibrato LFO counter.
`define OPL3_ADDR_W     3
`define OPL3_DATA_W     8

// Operator constants.
`define OPL3_VIB_FNUM_SHIFT 7     // Vibrato depth taken from fnum MSBs.
`define OPL3_WAVE_BITS      10    // Phase bits fed to the shaper.
`define OPL3_WAVE_GAIN      3     // Left shift into the output range.
`define OPL3_SQUARE_AMP     4095  // Largest positive sample.

`endif

/* src/opl3_reg_pkg.sv */
`default_nettype none

`include "opl3_settings.svh"

package opl3_reg_pkg;

    // Register field vectors.
    typedef logic [`OPL3_FNUM_W-1:0]  fnum_t;
    typedef logic [`OPL3_BLOCK_W-1:0] block_t;
    typedef logic [`OPL3_MULT_W-1:0]  mult_t;
    typedef logic [`OPL3_WS_W-1:0]    ws_field_t;

    // Write bus.
    typedef logic [`OPL3_ADDR_W-1:0]  reg_addr_t;
    typedef logic [`OPL3_DATA_W-1:0]  reg_data_t;

    // Address map.
    localparam reg_addr_t REG_FNUM_LO     = reg_addr_t'(0);  // fnum[7:0].
    localparam reg_addr_t REG_FNUM_HI_KEY = reg_addr_t'(1);  // fnum[9:8], block, restart.
    localparam reg_addr_t REG_MULT_VIB    = reg_addr_t'(2);  // mult, vib, dvb.
    localparam reg_addr_t REG_WAVE        = reg_addr_t'(3);  // ws.

endpackage

`default_nettype wire

/* src/opl3_op_pkg.sv */
`default_nettype none

`include "opl3_settings.svh"

package opl3_op_pkg;

    typedef logic [`OPL3_PHASE_W-1:0]          phase_t;    // Phase and increment.
    typedef logic signed [`OPL3_OUT_W-1:0]     op_out_t;   // Output sample.
    typedef logic [`OPL3_ENV_W-1:0]            env_t;      // Shift steps.
    typedef logic [`OPL3_VIB_IDX_W-1:0]        vib_idx_t;  // LFO counter.

    // Decoded waveform select.
    typedef enum logic [`OPL3_WS_W-1:0] {
        WAVE_SAW    = 2'd0,  // Plain ramp.
        WAVE_HALF   = 2'd1,  // Positive half only.
        WAVE_ABS    = 2'd2,  // Rectified.
        WAVE_SQUARE = 2'd3   // Full scale by phase MSB.
    } waveform_e;

endpackage

`default_nettype wire

/* src/operator_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module operator_regs
    import opl3_reg_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    input  wire            wr_en,
    input  wire reg_addr_t wr_addr,
    input  wire reg_data_t wr_data,
    output fnum_t          fnum,
    output block_t         block,
    output mult_t          mult,
    output logic           vib,
    output logic           dvb,
    output ws_field_t      ws,
    output logic           key_restart
);

    // ######################################################################
    // Field registers.
    // ######################################################################
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fnum        <= '0;
            block       <= '0;
            mult        <= '0;
            vib         <= 1'b0;
            dvb         <= 1'b0;
            ws          <= '0;
            key_restart <= 1'b0;
        end else begin
            key_restart <= 1'b0;  // Single cycle pulse.
            if (wr_en) begin
                case (wr_addr)
                    REG_FNUM_LO: begin
                        fnum[7:0] <= wr_data;
                    end
                    REG_FNUM_HI_KEY: begin
                        fnum[9:8]   <= wr_data[1:0];
                        block       <= wr_data[4:2];
                        key_restart <= 1'b1;  // Key write restarts phase.
                    end
                    REG_MULT_VIB: begin
                        mult <= wr_data[3:0];
                        vib  <= wr_data[4];
                        dvb  <= wr_data[5];  // Deep vibrato.
                    end
                    REG_WAVE: begin
                        ws <= wr_data[1:0];
                    end
                    default: begin
                        // Unmapped address.
                    end
                endcase
            end
        end
    end

    // Back to back restarts only from back to back key writes.
    a_restart_pulse: assert property (
        @(posedge clk) disable iff (!arst_n)
        (key_restart && $past(key_restart))
            |-> $past(wr_en && (wr_addr == REG_FNUM_HI_KEY))
    ) else $error("key_restart held without a second key write");

endmodule

`default_nettype wire

/* src/nco.sv */
`timescale 1ns/1ps
`default_nettype none

`include "opl3_settings.svh"

module nco
    import opl3_reg_pkg::*;
    import opl3_op_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    input  wire            en,
    input  wire phase_t    phase_inc,
    input  wire            key_restart,
    input  wire ws_field_t ws,
    input  wire env_t      env,
    output op_out_t        out
);

    localparam op_out_t AMP_POS = op_out_t'(`OPL3_SQUARE_AMP);
    localparam op_out_t AMP_NEG = op_out_t'(-`OPL3_SQUARE_AMP);

    phase_t                             phase;
    waveform_e                          wave;
    logic signed [`OPL3_WAVE_BITS-1:0]  top_bits;  // Phase MSBs as signed.
    op_out_t                            p;
    op_out_t                            neg_p;
    op_out_t                            shaped;

    // ######################################################################
    // Phase accumulator.
    // ######################################################################
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            phase <= '0;
        else if (key_restart)
            phase <= '0;  // Restart wins over accumulate.
        else if (en)
            phase <= phase + phase_inc;
    end

    // ######################################################################
    // Waveform shaper.
    // ######################################################################
    always_comb begin
        wave     = waveform_e'(ws);
        top_bits = phase[`OPL3_PHASE_W-1 -: `OPL3_WAVE_BITS];
        p        = op_out_t'(top_bits) <<< `OPL3_WAVE_GAIN;  // Sign extended.
        neg_p    = -p;
        shaped   = p;
        case (wave)
            WAVE_SAW: begin
                shaped = p;
            end
            WAVE_HALF: begin
                shaped = (p < 0) ? '0 : p;  // Negative half muted.
            end
            WAVE_ABS: begin
                if (p < 0)
                    shaped = (neg_p < 0) ? AMP_POS : neg_p;  // -4096 saturates.
                else
                    shaped = p;
            end
            WAVE_SQUARE: begin
                shaped = phase[`OPL3_PHASE_W-1] ? AMP_NEG : AMP_POS;
            end
        endcase
    end

    // Attenuated sample, one cycle behind the phase.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            out <= '0;
        else
            out <= shaped >>> env;  // Arithmetic, keeps sign.
    end

    // Restart and sample in one cycle.
    a_restart_clears: assert property (
        @(posedge clk) disable iff (!arst_n)
        (key_restart && en) |=> (phase == '0)
    ) else $error("phase not cleared by restart during sample");

endmodule

`default_nettype wire

/* src/nco_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "opl3_settings.svh"

module nco_control
    import opl3_reg_pkg::*;
    import opl3_op_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    input  wire            en,
    input  wire fnum_t     fnum,
    input  wire block_t    block,
    input  wire mult_t     mult,
    input  wire            vib,
    input  wire            dvb,
    input  wire ws_field_t ws,
    input  wire            key_restart,
    input  wire env_t      env,
    output op_out_t        out
);

    phase_t   pre_mult;      // fnum shifted by block.
    phase_t   post_mult;     // After multiplier table.
    phase_t   phase_inc_p0;
    phase_t   phase_inc;
    vib_idx_t vib_idx;
    vib_idx_t vib_idx_next;
    fnum_t    delta0;
    fnum_t    delta1;
    fnum_t    delta2;
    fnum_t    delta3;

    // ######################################################################
    // Increment pipeline. Four stages from fnum to phase_inc.
    // ######################################################################
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pre_mult     <= '0;
            post_mult    <= '0;
            phase_inc_p0 <= '0;
            phase_inc    <= '0;
        end else begin
            pre_mult <= phase_t'(fnum) << block;
            case (mult)
                4'h0:       post_mult <= pre_mult >> 1;  // One half.
                4'hA, 4'hB: post_mult <= phase_t'(pre_mult * 10);
                4'hC, 4'hD: post_mult <= phase_t'(pre_mult * 12);
                4'hE, 4'hF: post_mult <= phase_t'(pre_mult * 15);
                default:    post_mult <= pre_mult * mult;  // 1 to 9 direct.
            endcase
            phase_inc_p0 <= post_mult;  // Extra stage after the multiplier.
            if (vib)
                phase_inc <= phase_inc_p0 + phase_t'(delta3);  // Wraps mod 2^20.
            else
                phase_inc <= phase_inc_p0;
        end
    end

    // ######################################################################
    // Vibrato LFO. Steps once per sample.
    // ######################################################################
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            vib_idx <= '0;
        else
            vib_idx <= vib_idx_next;
    end

    // Deviation follows the next count, so each sample sees its own index.
    always_comb begin
        vib_idx_next = en ? vib_idx + 1'b1 : vib_idx;
        delta0 = fnum >> `OPL3_VIB_FNUM_SHIFT;
        delta1 = (vib_idx_next[11:10] == 2'b11) ? delta0 >> 1 : delta0;  // Shallow quarter.
        delta2 = dvb ? delta1 : delta1 >> 1;  // Half depth without dvb.
        delta3 = vib_idx_next[12] ? ~delta2 : delta2;  // Second half inverted.
    end

    // Multiplier must be defined once out of reset.
    a_mult_known: assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown(mult)
    ) else $error("mult has unknown bits");

    nco u_nco (
        .clk         (clk),
        .arst_n      (arst_n),
        .en          (en),
        .phase_inc   (phase_inc),
        .key_restart (key_restart),
        .ws          (ws),
        .env         (env),
        .out         (out)
    );

endmodule

`default_nettype wire

/* src/operator_top.sv */
`timescale 1ns/1ps
`default_nettype none

module operator_top
    import opl3_reg_pkg::*;
    import opl3_op_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    input  wire            wr_en,
    input  wire reg_addr_t wr_addr,
    input  wire reg_data_t wr_data,
    input  wire            sample_en,
    input  wire env_t      env,
    output op_out_t        out
);

    // Register fields into the phase path.
    fnum_t     fnum;
    block_t    block;
    mult_t     mult;
    logic      vib;
    logic      dvb;
    ws_field_t ws;
    logic      key_restart;

    operator_regs u_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .fnum        (fnum),
        .block       (block),
        .mult        (mult),
        .vib         (vib),
        .dvb         (dvb),
        .ws          (ws),
        .key_restart (key_restart)
    );

    nco_control u_nco_control (
        .clk         (clk),
        .arst_n      (arst_n),
        .en          (sample_en),
        .fnum        (fnum),
        .block       (block),
        .mult        (mult),
        .vib         (vib),
        .dvb         (dvb),
        .ws          (ws),
        .key_restart (key_restart),
        .env         (env),
        .out         (out)
    );

endmodule

`default_nettype wire

/* bench/operator_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "opl3_settings.svh"

module operator_checker
    import opl3_reg_pkg::*;
    import opl3_op_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    input  wire            wr_en,
    input  wire reg_addr_t wr_addr,
    input  wire reg_data_t wr_data,
    input  wire            sample_en,
    input  wire env_t      env,
    input  wire op_out_t   out
);

    // Twice the frequency factor per mult code, so mult 0 stays exact.
    localparam int MULT_X2 [16] = '{1, 2, 4, 6, 8, 10, 12, 14, 16, 18, 20, 20, 24, 24, 30, 30};

    // Shadow copy of the register block.
    fnum_t     m_fnum;
    block_t    m_block;
    mult_t     m_mult;
    logic      m_vib;
    logic      m_dvb;
    ws_field_t m_ws;
    phase_t    m_phase;  // Modelled accumulator.
    vib_idx_t  m_idx;    // Modelled LFO count.

    // Expected samples in flight toward out.
    logic      due1;
    logic      due2;
    op_out_t   exp1;
    op_out_t   exp2;
    logic      busy;

    int error_count = 0;
    int check_count = 0;
    int test_errors = 0;
    int test_samples = 0;

    assign busy = due1 | due2;

    // ######################################################################
    // Reference model of the increment and the output rule.
    // ######################################################################
    function automatic phase_t scaled_inc(fnum_t f, block_t b, mult_t m);
        longint base;
        base = longint'(f) << b;
        return phase_t'((base * MULT_X2[m]) / 2);
    endfunction

    function automatic phase_t vib_dev(fnum_t f, vib_idx_t i, logic deep);
        logic [9:0] d;
        d = 10'(f >> 7);
        if (i[11] && i[10])
            d = d >> 1;  // Shallow quarter.
        if (!deep)
            d = d >> 1;
        if (i[12])
            d = ~d;      // Second half of the LFO.
        return phase_t'(d);
    endfunction

    function automatic op_out_t expected_out(phase_t ph, ws_field_t w, env_t e);
        int t;
        int p;
        int r;
        t = int'(ph[19:10]);
        if (t >= 512)
            t = t - 1024;  // Top bits as signed.
        p = t * 8;
        case (w)
            2'd0: r = p;
            2'd1: r = (p < 0) ? 0 : p;
            2'd2: begin
                r = (p < 0) ? -p : p;
                if (r > 4095)
                    r = 4095;
            end
            default: r = ph[19] ? -4095 : 4095;
        endcase
        r = r >>> e;
        return op_out_t'(r);
    endfunction

    task automatic compare_out(op_out_t exp_val, string what);
        check_count++;
        if (out !== exp_val) begin
            $display("[ERROR] out got %h exp %h (%s)", out, exp_val, what);
            error_count++;
            test_errors++;
        end
    endtask

    // ######################################################################
    // Bus follower and per-sample comparison.
    // ######################################################################
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_fnum  = '0;
            m_block = '0;
            m_mult  = '0;
            m_vib   = 1'b0;
            m_dvb   = 1'b0;
            m_ws    = '0;
            m_phase = '0;
            m_idx   = '0;
            due1    = 1'b0;
            due2    = 1'b0;
            exp1    = '0;
            exp2    = '0;
        end else begin
            if (due2)
                compare_out(exp2, "sample");  // out of the pulse two edges back.
            due2 = due1;
            exp2 = exp1;
            due1 = 1'b0;
            if (wr_en) begin
                case (wr_addr)
                    3'd0: m_fnum[7:0] = wr_data;
                    3'd1: begin
                        m_fnum[9:8] = wr_data[1:0];
                        m_block     = wr_data[4:2];
                        m_phase     = '0;  // Key restart.
                    end
                    3'd2: begin
                        m_mult = wr_data[3:0];
                        m_vib  = wr_data[4];
                        m_dvb  = wr_data[5];
                    end
                    3'd3: m_ws = wr_data[1:0];
                    default: ;
                endcase
            end
            if (sample_en) begin
                m_phase = m_phase + scaled_inc(m_fnum, m_block, m_mult);
                if (m_vib)
                    m_phase = m_phase + vib_dev(m_fnum, m_idx, m_dvb);
                m_idx = m_idx + 1'b1;
                exp1  = expected_out(m_phase, m_ws, env);
                due1  = 1'b1;
                test_samples++;
            end
        end
    end

    // Called by the testbench once out has settled.
    task automatic end_test(int id, op_out_t final_exp);
        compare_out(final_exp, "final value");
        $display("test %0d done, %0d samples, %0d mismatches", id, test_samples, test_errors);
        test_errors  = 0;
        test_samples = 0;
    endtask

endmodule

`default_nettype wire

/* bench/operator_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module operator_tb
    import opl3_reg_pkg::*;
    import opl3_op_pkg::*;
();

    logic      clk;
    logic      arst_n;
    logic      wr_en;
    reg_addr_t wr_addr;
    reg_data_t wr_data;
    logic      sample_en;
    env_t      env;
    op_out_t   out;

    int    fd;
    int    n_fields;
    int    test_id;
    logic  idle;
    logic  aborted;
    string line;
    int    p_fnum;
    int    p_block;
    int    p_mult;
    int    p_vib;
    int    p_dvb;
    int    p_ws;
    int    p_env;
    int    p_n;
    int    p_exp;

    operator_top UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .sample_en (sample_en),
        .env       (env),
        .out       (out)
    );

    operator_checker u_chk (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .sample_en (sample_en),
        .env       (env),
        .out       (out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period.
    end

    // ######################################################################
    // Stimulus tasks, all driven on the falling edge.
    // ######################################################################
    task automatic write_reg(int addr, int data);
        @(negedge clk);
        wr_en   = 1'b1;
        wr_addr = reg_addr_t'(addr);
        wr_data = reg_data_t'(data);
        @(negedge clk);
        wr_en   = 1'b0;
    endtask

    task automatic send_samples(int count);
        int gap;
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            sample_en = 1'b1;
            gap = $urandom % 4;  // Gap 0 keeps the pulse high for the next one.
            if (gap > 0) begin
                @(negedge clk);
                sample_en = 1'b0;
                repeat (gap - 1) @(negedge clk);
            end
        end
        @(negedge clk);
        sample_en = 1'b0;
    endtask

    task automatic wait_checker_idle(output logic done);
        int cycles;
        cycles = 0;
        while (u_chk.busy && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        done = !u_chk.busy;
        if (!done)
            $display("Timeout waiting for the last sample to reach out");
    endtask

    // ######################################################################
    // Main sequence.
    // ######################################################################
    initial begin
        arst_n    = 1'b0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        sample_en = 1'b0;
        env       = '0;
        aborted   = 1'b0;
        void'($urandom(82));  // One seed for the whole run.
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);

        // Reset state only. No register written.
        send_samples(8);
        wait_checker_idle(idle);
        if (idle)
            u_chk.end_test(0, '0);
        else
            aborted = 1'b1;

        test_id = 1;
        fd = $fopen("bench/operator_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/operator_patterns.txt");
            aborted = 1'b1;
        end else begin
            while (!aborted && !$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    n_fields = $sscanf(line, "%h %h %h %h %h %h %h %d %h", p_fnum, p_block,
                                       p_mult, p_vib, p_dvb, p_ws, p_env, p_n, p_exp);
                    if (n_fields == 9) begin
                        write_reg(0, p_fnum & 8'hFF);
                        write_reg(1, ((p_block & 7) << 2) | ((p_fnum >> 8) & 3));
                        write_reg(2, ((p_dvb & 1) << 5) | ((p_vib & 1) << 4) | (p_mult & 15));
                        write_reg(3, p_ws & 3);
                        env = env_t'(p_env);
                        repeat (8) @(negedge clk);  // Increment pipeline settles.
                        send_samples(p_n);
                        wait_checker_idle(idle);
                        if (idle) begin
                            u_chk.end_test(test_id, op_out_t'(p_exp));
                            test_id++;
                        end else begin
                            aborted = 1'b1;
                        end
                    end
                end
            end
            $fclose(fd);
        end

        $display("%0d tests, %0d checks, %0d errors", test_id, u_chk.check_count,
                 u_chk.error_count);
        if (aborted || u_chk.error_count != 0)
            $display("TEST FAILED");
        else
            $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/operator_patterns.txt */
# Columns in hex except n: fnum block mult vib dvb ws env n(decimal) expected_final_out
# Each line writes all four registers, so every test starts from a key restart.
100 0 0 0 0 0 0 64 0040
100 0 1 0 0 0 0 64 0080
100 0 2 0 0 0 0 64 0100
100 0 3 0 0 0 0 64 0180
100 0 4 0 0 0 0 64 0200
100 0 5 0 0 0 0 64 0280
100 0 6 0 0 0 0 64 0300
100 0 7 0 0 0 0 64 0380
100 0 8 0 0 0 0 64 0400
100 0 9 0 0 0 0 64 0480
100 0 a 0 0 0 0 64 0500
100 0 b 0 0 0 0 64 0500
100 0 c 0 0 0 0 64 0600
100 0 d 0 0 0 0 64 0600
100 0 e 0 0 0 0 64 0780
100 0 f 0 0 0 0 64 0780
100 0 1 0 0 0 0 16 0020
100 1 1 0 0 0 0 16 0040
100 2 1 0 0 0 0 16 0080
100 3 1 0 0 0 0 16 0100
100 4 1 0 0 0 0 16 0200
100 5 1 0 0 0 0 16 0400
100 6 1 0 0 0 0 16 0800
100 7 1 0 0 0 0 16 1000
200 7 1 0 0 0 0 28 1800
200 7 1 0 0 1 0 28 0000
200 7 1 0 0 2 0 28 0800
200 7 1 0 0 3 0 28 1001
200 7 1 0 0 0 0 28 1800
200 7 1 0 0 0 3 28 1f00
200 7 1 0 0 0 f 28 1fff
080 0 1 1 1 0 0 4096 1a58
080 0 1 1 0 0 0 4096 0588

/* sim.f */
+incdir+src
src/opl3_reg_pkg.sv
src/opl3_op_pkg.sv
src/operator_regs.sv
src/nco.sv
src/nco_control.sv
src/operator_top.sv
bench/operator_checker.sv
bench/operator_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module operator_tb \
    -o operator_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/operator_sim > sim.log 2>&1 || echo "Simulator returned an error" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; } || exit 0
